// ==== source/main_pkg.sv ====
// ************************************************
// main bus package
// ************************************************
`default_nettype none

package main_pkg;

    typedef logic [23:1] addr_t;   // cpu word address
    typedef logic [15:0] data_t;
    typedef logic [ 1:0] dsn_t;    // {uds_n, lds_n}

    localparam int WRAM_AW = 14;
    localparam int OBJ_AW  = 9;

    typedef enum logic [2:0] {
        RGN_NONE, RGN_WRAM, RGN_IO, RGN_SYS1, RGN_SYS2, RGN_STATUS
    } region_e;

    // register bus select, same code as A[3:2] inside the io area
    typedef enum logic [1:0] { SEL_CAB1, SEL_CAB2, SEL_SYS1, SEL_SYS2 } sel_e;

    localparam logic [4:0] WRAM_TAG    = 5'b00111;   // 38_0000-3F_FFFF
    localparam logic [2:0] MISC_TAG    = 3'b010;
    localparam logic [2:0] IO_AREA     = 3'd2;
    localparam logic [2:0] STATUS_AREA = 3'd5;

    localparam int SYS1_PRI    = 14;
    localparam int SYS1_IRQ_EN = 10;
    localparam int SYS1_VFLIP  = 6;
    localparam int SYS1_HFLIP  = 5;
    localparam int SYS1_DMA_GO = 0;
    localparam int SYS2_BANK_HI = 7;
    localparam int SYS2_BANK_LO = 4;

    localparam int STAT_DMA_BUSY = 0;
    localparam int STAT_IRQ      = 1;

    localparam int unsigned OBJ_SRC = 0;   // dma source, work ram word

    function automatic region_e decode_region(addr_t a);
        if (a[23:19] == WRAM_TAG) return RGN_WRAM;
        if (a[23:21] == MISC_TAG && a[20:18] == IO_AREA) begin
            case (a[3:2])
                2'd2:    return RGN_SYS1;
                2'd3:    return RGN_SYS2;
                default: return RGN_IO;     // cabinet words
            endcase
        end
        if (a[23:21] == MISC_TAG && a[20:18] == STATUS_AREA) return RGN_STATUS;
        return RGN_NONE;
    endfunction

endpackage

`default_nettype wire

// ==== source/main_ifs.sv ====
// ************************************************
// register bus and ram port
// ************************************************
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
    import main_pkg::*;

    sel_e       sel;
    logic       wr;      // one clock pulse
    logic [1:0] be;      // {upper, lower}
    data_t      wdata;
    data_t      rdata;

    modport ctrl (output sel, wr, be, wdata, input rdata);
    modport regs (input sel, wr, be, wdata, output rdata);
endinterface

interface ram_port_if #(parameter int AW = main_pkg::WRAM_AW);
    import main_pkg::*;

    logic          req;    // held until ack
    logic          we;
    logic [AW-1:0] addr;
    logic [1:0]    be;
    data_t         wdata;
    logic          ack;    // single clock
    data_t         rdata;  // valid with ack

    modport master (output req, we, addr, be, wdata, input ack, rdata);
    modport slave  (input req, we, addr, be, wdata, output ack, rdata);
endinterface

`default_nettype wire

// ==== source/word_ram.sv ====
// ************************************************
// 16-bit word ram
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int AW = 10
) (
    input  logic            clk,
    input  logic            we,
    input  logic [1:0]      be,      // {upper, lower}
    input  logic [AW-1:0]   addr,
    input  main_pkg::data_t wdata,
    output main_pkg::data_t rdata
);
    import main_pkg::*;

    data_t mem [2**AW];

    always_ff @(posedge clk) begin
        if (we && be[1]) mem[addr][15:8] <= wdata[15:8];
        if (we && be[0]) mem[addr][ 7:0] <= wdata[ 7:0];
        rdata <= mem[addr];   // read before write
    end

endmodule

`default_nettype wire

// ==== source/addr_decoder.sv ====
// ************************************************
// cpu bus decoder and dtack
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module addr_decoder #(
    parameter int AW = main_pkg::WRAM_AW
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            as_n,
    input  main_pkg::dsn_t  dsn,
    input  logic            rnw,
    input  main_pkg::addr_t addr,
    input  main_pkg::data_t dout,
    input  logic            dma_busy,
    input  logic            irq_pending,
    output main_pkg::data_t din,
    output logic            dtack_n,
    reg_bus_if.ctrl         regs,
    ram_port_if.master      ram
);
    import main_pkg::*;

    typedef enum logic [1:0] { ST_IDLE, ST_ACCESS, ST_DONE, ST_WAIT } state_e;

    state_e  state;
    region_e region, cur_region;
    data_t   status, rd_mux;
    logic    start;

    assign start      = state == ST_IDLE && !as_n && dsn != 2'b11;
    assign cur_region = decode_region(addr);

    always_comb begin
        status                = '0;
        status[STAT_DMA_BUSY] = dma_busy;
        status[STAT_IRQ]      = irq_pending;
    end

    always_comb begin
        case (region)
            RGN_IO, RGN_SYS1, RGN_SYS2: rd_mux = regs.rdata;
            RGN_STATUS:                 rd_mux = status;
            default:                    rd_mux = '0;   // unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            region   <= RGN_NONE;
            regs.wr  <= 1'b0;
            ram.req  <= 1'b0;
            dtack_n  <= 1'b1;
        end else begin
            regs.wr <= 1'b0;
            case (state)
                ST_IDLE: if (start) begin
                    region  <= cur_region;
                    regs.wr <= !rnw && (cur_region == RGN_SYS1 || cur_region == RGN_SYS2);
                    ram.req <= cur_region == RGN_WRAM;
                    state   <= ST_ACCESS;
                end
                ST_ACCESS: if (region != RGN_WRAM || ram.ack) begin
                    ram.req <= 1'b0;
                    state   <= ST_DONE;
                end
                ST_DONE: begin
                    dtack_n <= 1'b0;
                    state   <= ST_WAIT;
                end
                default: if (as_n) begin   // wait for the cpu to end the cycle
                    dtack_n <= 1'b1;
                    state   <= ST_IDLE;
                end
            endcase
        end
    end

    // cycle payload, held for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            regs.sel   <= sel_e'(addr[3:2]);
            regs.be    <= ~dsn;
            regs.wdata <= dout;
            ram.we     <= ~rnw;
            ram.addr   <= addr[AW:1];   // mirrored over the region
            ram.be     <= ~dsn;
            ram.wdata  <= dout;
        end
        if (state == ST_ACCESS && (region != RGN_WRAM || ram.ack))
            din <= region == RGN_WRAM ? ram.rdata : rd_mux;
    end

endmodule

`default_nettype wire

// ==== source/sys_latches.sv ====
// ************************************************
// system latches and vblank irq
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module sys_latches (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       lvbl,
    input  logic [6:0] joy1,
    input  logic [6:0] joy2,
    input  logic       start1,
    input  logic       start2,
    input  logic [3:0] coin,
    input  logic [3:0] service,
    input  logic [3:0] dipsw,
    input  logic       dma_started,
    output logic       vflip,
    output logic       hflip,
    output logic       pri,
    output logic [3:0] bank,
    output logic       irq5,
    output logic       irq_pending,
    output logic       dma_go,
    reg_bus_if.regs    bus
);
    import main_pkg::*;

    data_t sys1, sys2, cab1, cab2;
    logic  lvbl_l, irq;

    function automatic data_t lane_merge(data_t old, data_t nxt, logic [1:0] be);
        lane_merge = old;
        if (be[1]) lane_merge[15:8] = nxt[15:8];
        if (be[0]) lane_merge[ 7:0] = nxt[ 7:0];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sys1   <= '0;
            sys2   <= '0;
            lvbl_l <= 1'b1;
            irq    <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (bus.wr && bus.sel == SEL_SYS1) sys1 <= lane_merge(sys1, bus.wdata, bus.be);
            if (bus.wr && bus.sel == SEL_SYS2) sys2 <= lane_merge(sys2, bus.wdata, bus.be);
            if (dma_started) sys1[SYS1_DMA_GO] <= 1'b0;   // self clearing
            if (!sys1[SYS1_IRQ_EN])
                irq <= 1'b0;
            else if (lvbl_l && !lvbl)
                irq <= 1'b1;   // blanking starts
        end
    end

    assign cab1 = {start2, joy2, start1, joy1};
    assign cab2 = {4'd0, dipsw, service, coin};

    always_comb begin
        case (bus.sel)
            SEL_CAB1: bus.rdata = cab1;
            SEL_CAB2: bus.rdata = cab2;
            SEL_SYS1: bus.rdata = sys1;
            default:  bus.rdata = sys2;
        endcase
    end

    assign pri         = sys1[SYS1_PRI];
    assign vflip       = sys1[SYS1_VFLIP];
    assign hflip       = sys1[SYS1_HFLIP];
    assign dma_go      = sys1[SYS1_DMA_GO];
    assign bank        = sys2[SYS2_BANK_HI:SYS2_BANK_LO];
    assign irq5        = irq;
    assign irq_pending = irq;

endmodule

`default_nettype wire

// ==== source/ram_arbiter.sv ====
// ************************************************
// work ram arbiter
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter #(
    parameter int AW = main_pkg::WRAM_AW
) (
    input  logic            clk,
    input  logic            rst_n,
    input  main_pkg::data_t mem_rdata,
    output logic            mem_we,
    output logic [AW-1:0]   mem_addr,
    output logic [1:0]      mem_be,
    output main_pkg::data_t mem_wdata,
    ram_port_if.slave       cpu,
    ram_port_if.slave       dma
);
    import main_pkg::*;

    logic g1, g2;            // grant in flight, ram stage then data stage
    logic own1, own2;        // 1 when dma owns the slot
    logic free, pick_cpu, pick_dma;

    assign free     = !g1 && !g2;   // one word per grant
    assign pick_cpu = free && cpu.req;
    assign pick_dma = free && !cpu.req && dma.req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            g1     <= 1'b0;
            g2     <= 1'b0;
            own1   <= 1'b0;
            own2   <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            g1     <= pick_cpu || pick_dma;
            g2     <= g1;
            own2   <= own1;
            mem_we <= (pick_cpu && cpu.we) || (pick_dma && dma.we);
            if (pick_cpu || pick_dma) own1 <= pick_dma;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_cpu) begin
            mem_addr  <= cpu.addr;
            mem_be    <= cpu.be;
            mem_wdata <= cpu.wdata;
        end else if (pick_dma) begin
            mem_addr  <= dma.addr;
            mem_be    <= dma.be;
            mem_wdata <= dma.wdata;
        end
    end

    // ram output lands one clock after the access
    assign cpu.ack   = g2 && !own2;
    assign dma.ack   = g2 && own2;
    assign cpu.rdata = mem_rdata;
    assign dma.rdata = mem_rdata;

endmodule

`default_nettype wire

// ==== source/obj_dma.sv ====
// ************************************************
// object dma
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_dma #(
    parameter int OBJ_AW = main_pkg::OBJ_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dma_go,
    output logic              dma_started,
    output logic              dma_busy,
    output logic              obj_we,
    output logic [OBJ_AW-1:0] obj_waddr,
    output main_pkg::data_t   obj_wdata,
    ram_port_if.master        src
);
    import main_pkg::*;

    localparam int SAW = $bits(src.addr);

    logic [OBJ_AW-1:0] idx;   // word being fetched

    assign dma_started = dma_go && !dma_busy;

    assign src.we    = 1'b0;   // read only peer
    assign src.be    = 2'b11;
    assign src.wdata = '0;
    assign src.addr  = SAW'(OBJ_SRC) + SAW'(idx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dma_busy <= 1'b0;
            src.req  <= 1'b0;
            obj_we   <= 1'b0;
            idx      <= '0;
        end else begin
            obj_we <= 1'b0;
            if (dma_started) begin
                dma_busy <= 1'b1;
                src.req  <= 1'b1;
                idx      <= '0;
            end else if (src.ack) begin
                obj_we <= 1'b1;
                if (idx == '1) src.req <= 1'b0;   // last word fetched
                else           idx     <= idx + 1'b1;
            end
            if (obj_we && obj_waddr == '1) dma_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (src.ack) begin
            obj_waddr <= idx;
            obj_wdata <= src.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/main_board.sv ====
// ************************************************
// main cpu board top
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module main_board #(
    parameter int WRAM_AW = main_pkg::WRAM_AW,
    parameter int OBJ_AW  = main_pkg::OBJ_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    // cpu bus
    input  logic              as_n,
    input  main_pkg::dsn_t    dsn,
    input  logic              rnw,
    input  main_pkg::addr_t   addr,
    input  main_pkg::data_t   dout,
    output main_pkg::data_t   din,
    output logic              dtack_n,
    // video and cabinet
    input  logic              lvbl,
    input  logic [6:0]        joy1,
    input  logic [6:0]        joy2,
    input  logic              start1,
    input  logic              start2,
    input  logic [3:0]        coin,
    input  logic [3:0]        service,
    input  logic [3:0]        dipsw,
    input  logic [OBJ_AW-1:0] obj_addr,
    output main_pkg::data_t   obj_data,
    output logic              irq5,
    output logic              vflip,
    output logic              hflip,
    output logic              pri,
    output logic [3:0]        bank
);
    import main_pkg::*;

    logic               dma_busy, irq_pending, dma_go, dma_started;
    logic               wram_we, obj_we;
    logic [WRAM_AW-1:0] wram_addr;
    logic [1:0]         wram_be;
    data_t              wram_wdata, wram_rdata, obj_wdata;
    logic [OBJ_AW-1:0]  obj_waddr, obj_ram_addr;

    reg_bus_if                    regs_bus ();
    ram_port_if #(.AW(WRAM_AW))   cpu_ram ();
    ram_port_if #(.AW(WRAM_AW))   dma_ram ();

    assign obj_ram_addr = obj_we ? obj_waddr : obj_addr;   // dma write steals the port

    addr_decoder #(.AW(WRAM_AW)) i_addr_decoder (
        .clk, .rst_n, .as_n, .dsn, .rnw, .addr, .dout, .dma_busy, .irq_pending,
        .din, .dtack_n, .regs(regs_bus.ctrl), .ram(cpu_ram.master)
    );

    sys_latches i_sys_latches (
        .clk, .rst_n, .lvbl, .joy1, .joy2, .start1, .start2, .coin, .service, .dipsw,
        .dma_started, .vflip, .hflip, .pri, .bank, .irq5, .irq_pending, .dma_go,
        .bus(regs_bus.regs)
    );

    ram_arbiter #(.AW(WRAM_AW)) i_ram_arbiter (
        .clk, .rst_n, .mem_rdata(wram_rdata), .mem_we(wram_we), .mem_addr(wram_addr),
        .mem_be(wram_be), .mem_wdata(wram_wdata), .cpu(cpu_ram.slave), .dma(dma_ram.slave)
    );

    obj_dma #(.OBJ_AW(OBJ_AW)) i_obj_dma (
        .clk, .rst_n, .dma_go, .dma_started, .dma_busy, .obj_we, .obj_waddr, .obj_wdata,
        .src(dma_ram.master)
    );

    word_ram #(.AW(WRAM_AW)) i_wram (
        .clk, .we(wram_we), .be(wram_be), .addr(wram_addr), .wdata(wram_wdata),
        .rdata(wram_rdata)
    );

    word_ram #(.AW(OBJ_AW)) i_obj_ram (
        .clk, .we(obj_we), .be(2'b11), .addr(obj_ram_addr), .wdata(obj_wdata),
        .rdata(obj_data)
    );

endmodule

`default_nettype wire

// ==== bench/main_board_properties.sv ====
// ************************************************
// bus protocol assertions
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module main_board_properties (
    input logic clk,
    input logic rst_n,
    input logic as_n,
    input logic dtack_n,
    input logic cpu_req,
    input logic cpu_ack,
    input logic dma_req,
    input logic dma_ack
);

    // no acknowledge outside a bus cycle
    dtack_idle: assert property (@(posedge clk) disable iff (!rst_n)
        as_n && $past(as_n) |-> dtack_n)
        else $error("dtack_n low while as_n high");

    dtack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(as_n) |=> dtack_n)
        else $error("dtack_n still low one clock after as_n rose");

    one_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_ack && dma_ack) && (!cpu_ack || cpu_req) && (!dma_ack || dma_req))
        else $error("arbiter acked both peers or a peer without a pending request");

endmodule

bind main_board main_board_properties i_main_board_properties (
    .clk, .rst_n, .as_n, .dtack_n,
    .cpu_req(cpu_ram.req), .cpu_ack(cpu_ram.ack),
    .dma_req(dma_ram.req), .dma_ack(dma_ram.ack)
);

`default_nettype wire

// ==== bench/main_board_tb.sv ====
// ************************************************
// main board testbench
// ************************************************
`timescale 1ns/1ps
`default_nettype none

module main_board_tb;
    import main_pkg::*;

    localparam int N_LATCH   = 32;
    localparam int N_RAM     = 48;
    localparam int N_CAB     = 8;
    localparam int DMA_WORDS = 2**OBJ_AW;
    // every bus access of all tests, dma polls and object ram reads counted generously
    localparam int N_ACCESS    = 3 + 3*N_LATCH + 4*N_RAM + 4 + 2*N_CAB + 12 + 6*DMA_WORDS;
    localparam int CYCLE_LIMIT = 200*N_ACCESS + 4*3*DMA_WORDS;   // 3 clocks per dma word

    localparam logic [23:0] WRAM_BASE   = 24'h380000;   // byte addresses
    localparam logic [23:0] CAB1_ADDR   = 24'h480000;
    localparam logic [23:0] CAB2_ADDR   = 24'h480004;
    localparam logic [23:0] SYS1_ADDR   = 24'h480008;
    localparam logic [23:0] SYS2_ADDR   = 24'h48000c;
    localparam logic [23:0] STATUS_ADDR = 24'h540000;

    logic              clk, rst_n, as_n, rnw, lvbl, start1, start2;
    dsn_t              dsn;
    addr_t             addr;
    data_t             dout, din, obj_data;
    logic              dtack_n, irq5, vflip, hflip, pri;
    logic [6:0]        joy1, joy2;
    logic [3:0]        coin, service, dipsw, bank;
    logic [OBJ_AW-1:0] obj_addr;

    data_t       wram_sh [2**WRAM_AW];   // cpu view of work ram
    data_t       sys1_sh, sys2_sh;
    logic        irq_sh;
    logic [31:0] lfsr = 32'h034f3ddb;
    int          errors = 0, checks = 0, tests = 0, errs_mark = 0, cycles = 0;
    logic [23:0] ram_addrs [$];
    string       what_q [$];
    data_t       got_q [$], exp_q [$];

    main_board #(.WRAM_AW(WRAM_AW), .OBJ_AW(OBJ_AW)) i_main_board (
        .clk, .rst_n, .as_n, .dsn, .rnw, .addr, .dout, .din, .dtack_n, .lvbl, .joy1, .joy2,
        .start1, .start2, .coin, .service, .dipsw, .obj_addr, .obj_data, .irq5, .vflip,
        .hflip, .pri, .bank
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d clock cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic dsn_t random_strobes();
        dsn_t s;
        s = dsn_t'(rand_bits(2));
        return (s == 2'b11) ? 2'b00 : s;   // both high would start no cycle
    endfunction

    function automatic data_t apply_strobes(input data_t old, input data_t nxt, input dsn_t s);
        data_t r;
        r = old;
        if (!s[1]) r[15:8] = nxt[15:8];
        if (!s[0]) r[7:0]  = nxt[7:0];
        return r;
    endfunction

    // expected read data from the board's address map
    function automatic data_t expected_read(input logic [23:0] ba);
        if (ba[23:19] == 5'b00111) return wram_sh[ba[WRAM_AW:1]];   // region mirrors
        if (ba[23:18] == 6'b010_010) begin
            case (ba[3:2])
                2'd0:    return {start2, joy2, start1, joy1};
                2'd1:    return {4'd0, dipsw, service, coin};
                2'd2:    return sys1_sh;
                default: return sys2_sh;
            endcase
        end
        if (ba[23:18] == 6'b010_101) return {14'd0, irq_sh, 1'b0};   // dma idle here
        return '0;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic bus_cycle(input logic [23:0] ba, input logic wr, input dsn_t s,
                             input data_t wd, output data_t rd);
        @(negedge clk);
        addr = ba[23:1];
        rnw  = !wr;
        dsn  = s;
        dout = wd;
        as_n = 1'b0;
        @(negedge clk);
        while (dtack_n) @(negedge clk);
        rd   = din;
        as_n = 1'b1;
        dsn  = 2'b11;
        rnw  = 1'b1;
        @(negedge clk);
        while (!dtack_n) @(negedge clk);   // dtack released before the next cycle
    endtask

    task automatic bus_write(input logic [23:0] ba, input dsn_t s, input data_t wd);
        data_t unused;
        bus_cycle(ba, 1'b1, s, wd, unused);
    endtask

    task automatic bus_read(input logic [23:0] ba, output data_t rd);
        bus_cycle(ba, 1'b0, 2'b00, '0, rd);
    endtask

    task automatic read_check(input logic [23:0] ba, input string what);
        data_t exp, got;
        exp = expected_read(ba);
        bus_read(ba, got);
        what_q.push_back(what);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // compares the queued reads
    always @(posedge clk) begin
        while (got_q.size() > 0)
            compare(what_q.pop_front(), 32'(got_q.pop_front()), 32'(exp_q.pop_front()));
    end

    task automatic end_test(input string name);
        @(posedge clk);
        @(negedge clk);
        tests++;
        $display("%-8s %s, %0d errors", name, (errors == errs_mark) ? "ok" : "bad",
                 errors - errs_mark);
        errs_mark = errors;
    endtask

    initial begin
        data_t       d, st;
        dsn_t        s;
        logic [23:0] ba;
        int          idx;
        logic        first;
        rst_n    = 1'b0;
        as_n     = 1'b1;
        dsn      = 2'b11;
        rnw      = 1'b1;
        addr     = '0;
        dout     = '0;
        lvbl     = 1'b1;
        joy1     = '0;
        joy2     = '0;
        start1   = 1'b0;
        start2   = 1'b0;
        coin     = '0;
        service  = '0;
        dipsw    = '0;
        obj_addr = '0;
        sys1_sh  = '0;
        sys2_sh  = '0;
        irq_sh   = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        compare("reset pins", 32'({dtack_n, irq5, vflip, hflip, pri, bank}), 32'h100);
        read_check(SYS1_ADDR, "sys1 after reset");
        read_check(SYS2_ADDR, "sys2 after reset");
        read_check(STATUS_ADDR, "status after reset");
        end_test("reset");

        for (int i = 0; i < N_LATCH; i++) begin
            ba = rand_bits(1) ? SYS2_ADDR : SYS1_ADDR;
            s  = random_strobes();
            d  = data_t'(rand_bits(16));
            if (ba == SYS1_ADDR) begin
                d[SYS1_DMA_GO] = 1'b0;   // keep the dma idle
                sys1_sh = apply_strobes(sys1_sh, d, s);
            end else begin
                sys2_sh = apply_strobes(sys2_sh, d, s);
            end
            bus_write(ba, s, d);
            compare("vflip/hflip/pri", 32'({vflip, hflip, pri}),
                    32'({sys1_sh[SYS1_VFLIP], sys1_sh[SYS1_HFLIP], sys1_sh[SYS1_PRI]}));
            compare("bank", 32'(bank), 32'(sys2_sh[7:4]));
            read_check(SYS1_ADDR, "sys1 readback");
            read_check(SYS2_ADDR, "sys2 readback");
        end
        end_test("latches");

        for (int i = 0; i < N_RAM; i++) begin
            ba = WRAM_BASE | 24'(rand_bits(18) << 1);
            d  = data_t'(rand_bits(16));
            wram_sh[ba[WRAM_AW:1]] = d;   // full word first, then a lane write
            bus_write(ba, 2'b00, d);
            s = random_strobes();
            d = data_t'(rand_bits(16));
            wram_sh[ba[WRAM_AW:1]] = apply_strobes(wram_sh[ba[WRAM_AW:1]], d, s);
            bus_write(ba, s, d);
            read_check(ba, "wram readback");
            ram_addrs.push_back(ba);
        end
        foreach (ram_addrs[i]) read_check(ram_addrs[i], "wram final");
        read_check(24'h000000, "unmapped");
        read_check(24'h200000, "unmapped");
        read_check(24'h4c0000, "unmapped misc area");
        read_check(24'hf00000, "unmapped");
        end_test("wram");

        for (int i = 0; i < N_CAB; i++) begin
            @(negedge clk);
            {joy2, joy1}           = 14'(rand_bits(14));
            {start2, start1}       = 2'(rand_bits(2));
            {dipsw, service, coin} = 12'(rand_bits(12));
            read_check(CAB1_ADDR, "cabinet word 1");
            read_check(CAB2_ADDR, "cabinet word 2");
        end
        end_test("cabinet");

        sys1_sh = '0;
        bus_write(SYS1_ADDR, 2'b00, 16'h0000);
        @(negedge clk);
        lvbl = 1'b0;   // vblank while masked
        repeat (2) @(negedge clk);
        compare("irq5 masked", 32'(irq5), 32'd0);
        lvbl    = 1'b1;
        d       = 16'(1 << SYS1_IRQ_EN);
        sys1_sh = apply_strobes(sys1_sh, d, 2'b01);
        bus_write(SYS1_ADDR, 2'b01, d);
        read_check(STATUS_ADDR, "status before vblank");
        @(negedge clk);
        lvbl = 1'b0;
        @(negedge clk);
        compare("irq5 on vblank", 32'(irq5), 32'd1);
        irq_sh = 1'b1;
        lvbl   = 1'b1;
        read_check(STATUS_ADDR, "status irq pending");
        sys1_sh = '0;
        bus_write(SYS1_ADDR, 2'b01, 16'h0000);
        irq_sh = 1'b0;
        compare("irq5 after disable", 32'(irq5), 32'd0);
        read_check(STATUS_ADDR, "status irq cleared");
        end_test("irq");

        for (int i = 0; i < DMA_WORDS; i++) begin
            d  = data_t'(rand_bits(16));
            ba = WRAM_BASE + 24'((OBJ_SRC + i) * 2);
            wram_sh[ba[WRAM_AW:1]] = d;
            bus_write(ba, 2'b00, d);
        end
        d       = 16'(1 << SYS1_DMA_GO);
        sys1_sh = apply_strobes(sys1_sh, d, 2'b10);
        sys1_sh[SYS1_DMA_GO] = 1'b0;   // engine clears it on start
        bus_write(SYS1_ADDR, 2'b10, d);
        first = 1'b1;
        do begin
            idx = int'(rand_bits(OBJ_AW));
            read_check(WRAM_BASE + 24'((OBJ_SRC + idx) * 2), "wram during dma");
            bus_read(STATUS_ADDR, st);
            if (first) compare("dma busy after start", 32'(st[0]), 32'd1);
            compare("status during dma", 32'(st[15:1]), 32'd0);
            first = 1'b0;
        end while (st[0]);
        for (int i = 0; i < DMA_WORDS; i++) begin
            @(negedge clk);
            obj_addr = OBJ_AW'(i);
            @(negedge clk);   // registered read
            compare("object ram", 32'(obj_data), 32'(wram_sh[OBJ_SRC + i]));
        end
        read_check(SYS1_ADDR, "sys1 after dma");
        end_test("dma");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/main_pkg.sv
source/main_ifs.sv
source/word_ram.sv
source/addr_decoder.sv
source/sys_latches.sv
source/ram_arbiter.sv
source/obj_dma.sv
source/main_board.sv
bench/main_board_properties.sv
bench/main_board_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= main_board_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
